/* source/video_timing_pkg.sv */
package video_timing_pkg;

	// horizontal, in cend units (7 MHz)
	localparam int hcnt_w = 9;

	localparam logic [hcnt_w-1:0] hblnk_beg = 9'd0; // video ends, blank begins
	localparam logic [hcnt_w-1:0] hsync_beg = 9'd10;
	localparam logic [hcnt_w-1:0] hsync_end = 9'd43; // 33 cend of sync
	localparam logic [hcnt_w-1:0] hblnk_end = 9'd88;

	// 256 pixel window
	localparam logic [hcnt_w-1:0] hpix_beg_pent = 9'd140;
	localparam logic [hcnt_w-1:0] hpix_end_pent = 9'd396;

	// 320 pixel window, centred on the same line
	localparam logic [hcnt_w-1:0] hpix_beg_atm = 9'd108;
	localparam logic [hcnt_w-1:0] hpix_end_atm = 9'd428;

	localparam logic [hcnt_w-1:0] hperiod = 9'd448; // 896 clk per line

	// vertical, in lines
	localparam int vcnt_w = 9;

	localparam logic [vcnt_w-1:0] vperiod   = 9'd320;
	localparam logic [vcnt_w-1:0] vblnk_beg = 9'd0;
	localparam logic [vcnt_w-1:0] vsync_beg = 9'd16;
	localparam logic [vcnt_w-1:0] vsync_end = 9'd20;
	localparam logic [vcnt_w-1:0] vblnk_end = 9'd32;
	localparam logic [vcnt_w-1:0] vpix_beg  = 9'd80; // 192 visible lines
	localparam logic [vcnt_w-1:0] vpix_end  = 9'd272;

endpackage

/* source/video_mem_pkg.sv */
package video_mem_pkg;

	localparam int addr_w = 14; // 16K words of video RAM

	// words fetched per visible line
	localparam logic [addr_w-1:0] words_pent = 14'd32; // 256 px / 8 px per word
	localparam logic [addr_w-1:0] words_atm  = 14'd80; // 320 px / 4 px per word

	// zx style attribute byte
	typedef struct packed
	{
		logic       flash; // not displayed here
		logic       bright;
		logic [2:0] paper;
		logic [2:0] ink;
	} attr_t;

	typedef struct packed
	{
		attr_t      attr;   // high byte
		logic [7:0] bitmap; // low byte, msb is leftmost dot
	} pent_word_t;

	// one RAM word, seen either as bitmap+attr or as four 4-bit pixels
	typedef union packed
	{
		pent_word_t      pent;
		logic [3:0][3:0] atm; // atm[3] shown first
	} disp_word_t;

endpackage

/* source/video_strobe_gen.sv */
`timescale 1ns/100ps

module video_strobe_gen
(
	input  logic clk,
	input  logic rst_n,
	output logic pre_cend, // one clock ahead of cend
	output logic cend      // 7 MHz working strobe
);

	logic phase; // toggles every clk

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			phase    <= 1'b0;
			pre_cend <= 1'b0;
			cend     <= 1'b0;
		end
		else
		begin
			phase    <= ~phase;
			pre_cend <= ~phase; // first clock after reset
			cend     <= phase;
		end
	end

endmodule

/* source/video_sync_h.sv */
`timescale 1ns/100ps

module video_sync_h
(
	input  logic clk,
	input  logic rst_n,
	input  logic cend,
	input  logic pre_cend,
	input  logic mode_atm_n_pent, // frame-latched mode, stable over a line
	output logic hblank,
	output logic hsync,
	output logic line_start,  // high during the cend where blank ends
	output logic hsync_start, // high during the cend where sync begins
	output logic hpix         // pixel gate
);

	logic [video_timing_pkg::hcnt_w-1:0] hcount;
	logic [video_timing_pkg::hcnt_w-1:0] hpix_beg;
	logic [video_timing_pkg::hcnt_w-1:0] hpix_end;

	// window bounds for the current mode
	assign hpix_beg = mode_atm_n_pent ? video_timing_pkg::hpix_beg_atm
	                                  : video_timing_pkg::hpix_beg_pent;
	assign hpix_end = mode_atm_n_pent ? video_timing_pkg::hpix_end_atm
	                                  : video_timing_pkg::hpix_end_pent;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			hcount <= '0;
		else if (cend)
		begin
			if (hcount == video_timing_pkg::hperiod - 1'b1)
				hcount <= '0; // line wrap
			else
				hcount <= hcount + 1'b1;
		end
	end

	// blank and sync registered on cend at their positions
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hblank <= 1'b0;
			hsync  <= 1'b0;
			hpix   <= 1'b0;
		end
		else if (cend)
		begin
			if (hcount == video_timing_pkg::hblnk_beg)
				hblank <= 1'b1;
			else if (hcount == video_timing_pkg::hblnk_end)
				hblank <= 1'b0;

			if (hcount == video_timing_pkg::hsync_beg)
				hsync <= 1'b1;
			else if (hcount == video_timing_pkg::hsync_end)
				hsync <= 1'b0;

			if (hcount == hpix_beg)
				hpix <= 1'b1;
			else if (hcount == hpix_end)
				hpix <= 1'b0;
		end
	end

	// strobes registered on pre_cend, so they line up with the next cend
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			line_start  <= 1'b0;
			hsync_start <= 1'b0;
		end
		else
		begin
			line_start  <= pre_cend && (hcount == video_timing_pkg::hblnk_end);
			hsync_start <= pre_cend && (hcount == video_timing_pkg::hsync_beg);
		end
	end

endmodule

/* source/video_sync_v.sv */
`timescale 1ns/100ps

module video_sync_v
(
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                hsync_start, // one per line
	input  logic                                mode_atm_n_pent,
	output logic                                vblank,
	output logic                                vsync,
	output logic                                vpix,
	output logic [video_timing_pkg::vcnt_w-2:0] vline, // 0..191 in visible area
	output logic                                frame_start,
	output logic                                mode_frame
);

	logic [video_timing_pkg::vcnt_w-1:0] vcount;
	logic                                last_line;

	assign last_line = (vcount == video_timing_pkg::vperiod - 1'b1);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			vcount <= '0;
			vblank <= 1'b0;
			vsync  <= 1'b0;
			vpix   <= 1'b0;
			vline  <= '0;
		end
		else if (hsync_start)
		begin
			vcount <= last_line ? '0 : vcount + 1'b1;

			if (vcount == video_timing_pkg::vblnk_beg)
				vblank <= 1'b1;
			else if (vcount == video_timing_pkg::vblnk_end)
				vblank <= 1'b0;

			if (vcount == video_timing_pkg::vsync_beg)
				vsync <= 1'b1;
			else if (vcount == video_timing_pkg::vsync_end)
				vsync <= 1'b0;

			if (vcount == video_timing_pkg::vpix_beg)
			begin
				vpix  <= 1'b1;
				vline <= '0; // first visible line
			end
			else if (vcount == video_timing_pkg::vpix_end)
				vpix <= 1'b0; // vline stays at 191
			else if (vpix)
				vline <= vline + 1'b1;
		end
	end

	// frame_start pulse and mode latch
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			frame_start <= 1'b0;
			mode_frame  <= 1'b0;
		end
		else
		begin
			frame_start <= hsync_start && last_line;
			if (frame_start)
				mode_frame <= mode_atm_n_pent; // new mode only from the next frame on
		end
	end

endmodule

/* source/video_fetch.sv */
`timescale 1ns/100ps

module video_fetch
(
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                cend,
	input  logic                                line_start,
	input  logic                                hpix,
	input  logic                                vpix,
	input  logic [video_timing_pkg::vcnt_w-2:0] vline,
	input  logic                                mode_frame, // 1 = atm
	output logic                                vid_rd,
	output logic [video_mem_pkg::addr_w-1:0]    vid_addr,
	input  logic [15:0]                         vid_data,
	output logic [3:0]                          pixel,
	output logic                                pixel_valid
);

	logic [video_mem_pkg::addr_w-1:0] line_words; // words per line, this mode
	logic [video_mem_pkg::addr_w-1:0] base_addr;
	logic [video_mem_pkg::addr_w-1:0] word_addr;  // next word after the line's first
	video_mem_pkg::disp_word_t        cur_word;
	video_mem_pkg::disp_word_t        next_word;
	video_mem_pkg::disp_word_t        show_word;
	logic [2:0]                       pix_idx;    // pixel within the word
	logic [2:0]                       last_idx;
	logic                             rd_d;       // read data valid this clock
	logic                             active;

	// one dot of the current word as a 4-bit colour index
	function automatic logic [3:0] decode_pix(input video_mem_pkg::disp_word_t w,
	                                          input logic [2:0] idx,
	                                          input logic atm);
		logic dot;
		dot = w.pent.bitmap[3'd7 - idx]; // msb first
		if (atm)
			return w.atm[2'd3 - idx[1:0]]; // high nibble first
		return {w.pent.attr.bright, dot ? w.pent.attr.ink : w.pent.attr.paper};
	endfunction

	assign active     = hpix & vpix;
	assign line_words = mode_frame ? video_mem_pkg::words_atm : video_mem_pkg::words_pent;
	assign base_addr  = line_words * vline;
	assign last_idx   = mode_frame ? 3'd3 : 3'd7;

	// first word at line_start, then one per last pixel of a word
	assign vid_rd   = (line_start & vpix) | (cend & active & (pix_idx == last_idx));
	assign vid_addr = line_start ? base_addr : word_addr;

	// word 0 of a new word is still in next_word, take it from there
	assign show_word = (pix_idx == 3'd0) ? next_word : cur_word;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			word_addr <= '0;
			rd_d      <= 1'b0;
		end
		else
		begin
			rd_d <= vid_rd;
			if (vid_rd)
				word_addr <= vid_addr + 1'b1;
		end
	end

	// ram answers on the pre_cend clock after the read
	always_ff @(posedge clk)
	begin
		if (rd_d)
			next_word <= vid_data;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pix_idx     <= '0;
			pixel_valid <= 1'b0;
		end
		else if (cend)
		begin
			pixel_valid <= active;
			if (active)
				pix_idx <= (pix_idx == last_idx) ? 3'd0 : pix_idx + 1'b1;
			else
				pix_idx <= '0; // realign for next line
		end
	end

	// pixel payload
	always_ff @(posedge clk)
	begin
		if (cend && active)
		begin
			pixel <= decode_pix(show_word, pix_idx, mode_frame);
			if (pix_idx == 3'd0)
				cur_word <= next_word; // word in use from now on
		end
	end

endmodule

/* source/video_arbiter.sv */
`timescale 1ns/100ps

module video_arbiter
(
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             vid_rd,   // fetch has priority
	input  logic [video_mem_pkg::addr_w-1:0] vid_addr,
	input  logic                             cpu_wr,   // one-clock strobe
	input  logic [video_mem_pkg::addr_w-1:0] cpu_addr,
	input  logic [15:0]                      cpu_data,
	output logic                             ram_we,
	output logic [video_mem_pkg::addr_w-1:0] ram_addr,
	output logic [15:0]                      ram_wdata
);

	logic                             pend_valid; // held write from a collision
	logic [video_mem_pkg::addr_w-1:0] pend_addr;
	logic [15:0]                      pend_data;

	// the clock after vid_rd never carries another read, so the slot drains there
	assign ram_we    = ~vid_rd & (pend_valid | cpu_wr);
	assign ram_addr  = vid_rd ? vid_addr : (pend_valid ? pend_addr : cpu_addr);
	assign ram_wdata = pend_valid ? pend_data : cpu_data;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pend_valid <= 1'b0;
		else
			pend_valid <= vid_rd & cpu_wr; // collision, write one clock later
	end

	always_ff @(posedge clk)
	begin
		if (vid_rd && cpu_wr)
		begin
			pend_addr <= cpu_addr;
			pend_data <= cpu_data;
		end
	end

endmodule

/* source/video_ram.sv */
`timescale 1ns/100ps

module video_ram
(
	input  logic                             clk,
	input  logic                             we,
	input  logic [video_mem_pkg::addr_w-1:0] addr,
	input  logic [15:0]                      wdata,
	output logic [15:0]                      rdata // valid the clock after addr
);

	logic [15:0] mem [0:(1 << video_mem_pkg::addr_w) - 1];

	always_ff @(posedge clk)
	begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr]; // old data on a write clock
	end

endmodule

/* source/video_top.sv */
`timescale 1ns/100ps

module video_top
(
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             mode_atm_n_pent,
	input  logic                             cpu_wr,
	input  logic [video_mem_pkg::addr_w-1:0] cpu_addr,
	input  logic [15:0]                      cpu_data,
	output logic                             hblank,
	output logic                             hsync,
	output logic                             vblank,
	output logic                             vsync,
	output logic                             pixel_valid,
	output logic [3:0]                       pixel
);

	logic                                pre_cend, cend;
	logic                                line_start, hsync_start, hpix;
	logic                                vpix, mode_frame;
	logic [video_timing_pkg::vcnt_w-2:0] vline;
	logic                                vid_rd;
	logic [video_mem_pkg::addr_w-1:0]    vid_addr, ram_addr;
	logic                                ram_we;
	logic [15:0]                         ram_wdata, ram_rdata;

	video_strobe_gen u_strobe (.clk, .rst_n, .pre_cend, .cend);

	// line timing follows the frame-latched mode
	video_sync_h u_sync_h (.clk, .rst_n, .cend, .pre_cend, .mode_atm_n_pent(mode_frame),
		.hblank, .hsync, .line_start, .hsync_start, .hpix);

	video_sync_v u_sync_v (.clk, .rst_n, .hsync_start, .mode_atm_n_pent,
		.vblank, .vsync, .vpix, .vline, .frame_start(), .mode_frame);

	video_fetch u_fetch (.clk, .rst_n, .cend, .line_start, .hpix, .vpix, .vline,
		.mode_frame, .vid_rd, .vid_addr, .vid_data(ram_rdata), .pixel, .pixel_valid);

	video_arbiter u_arb (.clk, .rst_n, .vid_rd, .vid_addr, .cpu_wr, .cpu_addr, .cpu_data,
		.ram_we, .ram_addr, .ram_wdata);

	video_ram u_ram (.clk, .we(ram_we), .addr(ram_addr), .wdata(ram_wdata),
		.rdata(ram_rdata));

endmodule

/* sim/video_tb.sv */
`timescale 1ns/100ps

module video_tb;

	localparam int frame_clks = 320 * 896;             // 320 lines of 896 clk
	localparam int max_cycles = 4 * frame_clks + 1000; // four frames and some slack

	logic                             clk;
	logic                             rst_n;
	logic                             mode_atm_n_pent;
	logic                             cpu_wr;
	logic [video_mem_pkg::addr_w-1:0] cpu_addr;
	logic [15:0]                      cpu_data;
	logic                             hblank, hsync, vblank, vsync, pixel_valid;
	logic [3:0]                       pixel;

	logic [15:0] mirror [0:(1 << video_mem_pkg::addr_w) - 1]; // expected RAM contents
	logic [video_mem_pkg::addr_w-1:0] wr_addr_q [$];             // writes of the current frame
	logic [15:0]                      wr_data_q [$];
	int   fd;
	int   run_cyc = 0; // clocks since reset release, odd values follow a cend edge
	// monitor state, counted in cend samples and lines
	int   h_cnt = 0, v_cnt = 0, px = 0, vis_line = 0, frames = 0;
	logic h_seen = 1'b0, frame_mode = 1'b0;
	logic hblank_q = 1'b0, hsync_q = 1'b0, vblank_q = 1'b0, vsync_q = 1'b0;
	logic pixel_valid_q = 1'b0;

	video_top DUT (.clk, .rst_n, .mode_atm_n_pent, .cpu_wr, .cpu_addr, .cpu_data,
		.hblank, .hsync, .vblank, .vsync, .pixel_valid, .pixel);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// odd multiplier, so every address bit reaches the word
	function automatic logic [15:0] fill_word(input int a);
		return 16'(a * 40503) ^ 16'(a >> 4) ^ 16'h3c5a;
	endfunction

	// colour index of dot px on visible line ln, from the mirror
	function automatic logic [3:0] expect_pixel(input int ln, input int px_i, input logic atm);
		video_mem_pkg::disp_word_t w;
		if (atm)
		begin
			w = mirror[ln * video_mem_pkg::words_atm + px_i / 4];
			return w.atm[3 - px_i % 4]; // high nibble leftmost
		end
		w = mirror[ln * video_mem_pkg::words_pent + px_i / 8];
		return {w.pent.attr.bright,
			w.pent.bitmap[7 - px_i % 8] ? w.pent.attr.ink : w.pent.attr.paper};
	endfunction

	// one cpu write, takes two clocks so writes come every other clock
	task automatic write_word(input logic [video_mem_pkg::addr_w-1:0] a, input logic [15:0] d);
		cpu_wr   <= 1'b1;
		cpu_addr <= a;
		cpu_data <= d;
		mirror[a] = d;
		@(posedge clk);
		cpu_wr <= 1'b0;
		@(posedge clk);
	endtask

	// writes up to the next mode record, mode unchanged at end of file
	task automatic read_group(output logic mode_next);
		logic [8*96-1:0] line;
		logic [31:0]     kind, addr, data;
		logic            done;
		done      = 1'b0;
		mode_next = mode_atm_n_pent;
		while (!done && !$feof(fd))
		begin
			line = '0;
			void'($fgets(line, fd));
			if ($sscanf(line, "%h %h %h", kind, addr, data) == 3) // comment lines fail here
			begin
				if (kind == 0)
				begin
					mode_next = data[0];
					done      = 1'b1;
				end
				else
				begin
					wr_addr_q.push_back(addr[video_mem_pkg::addr_w-1:0]);
					wr_data_q.push_back(data[15:0]);
				end
			end
		end
	endtask

	task automatic sample_outputs();
		if (hblank && !hblank_q)
		begin
			if (h_seen)
				check_val("hblank period", h_cnt + 1, 448);
			h_cnt  = 0;
			h_seen = 1'b1;
		end
		else
			h_cnt = h_cnt + 1;
		if (!hblank && hblank_q)
			check_val("hblank width", h_cnt, 88);
		if (hsync && !hsync_q)
			check_val("hsync start", h_cnt, 10);
		if (!hsync && hsync_q)
			check_val("hsync end", h_cnt, 43); // 33 cend of sync

		// vertical, one step per hsync rise
		if (vblank && !vblank_q)
		begin
			if (frames > 0)
			begin
				check_val("vblank period", v_cnt + 1, 320);
				check_val("visible lines", vis_line, 192);
			end
			v_cnt      = 0;
			vis_line   = 0;
			frame_mode = mode_atm_n_pent; // latched one line ago
			frames     = frames + 1;
		end
		else if (hsync && !hsync_q)
			v_cnt = v_cnt + 1;
		if (!vblank && vblank_q)
			check_val("vblank width", v_cnt, 32);
		if (vsync && !vsync_q)
			check_val("vsync start", v_cnt, 16);
		if (!vsync && vsync_q)
			check_val("vsync end", v_cnt, 20);

		if (pixel_valid)
		begin
			px = pixel_valid_q ? px + 1 : 0;
			check_val("pixel", pixel, expect_pixel(vis_line, px, frame_mode));
		end
		else if (pixel_valid_q)
		begin
			check_val("pixel_valid run", px + 1, frame_mode ? 320 : 256);
			vis_line = vis_line + 1;
		end
		{hblank_q, hsync_q, vblank_q, vsync_q} = {hblank, hsync, vblank, vsync};
		pixel_valid_q = pixel_valid;
	endtask

	always @(posedge clk)
	begin
		run_cyc <= rst_n ? run_cyc + 1 : 0;
		if (run_cyc >= max_cycles)
		begin
			$display("timeout: frames did not complete within %0d clocks", max_cycles);
			$display("Errors found");
			$fatal(1, "run stopped by timeout");
		end
	end

	// outputs settle after the cend edges, look at them half a clock later
	always @(negedge clk)
	begin
		if (rst_n && run_cyc >= 3 && run_cyc[0])
			sample_outputs();
	end

	initial
	begin
		int   m0;
		logic mode_next;
		void'($urandom(887));
		rst_n           = 1'b0;
		mode_atm_n_pent = 1'b0;
		cpu_wr          = 1'b0;
		cpu_addr        = '0;
		cpu_data        = '0;
		fd = $fopen("sim/testdata_video.txt", "r");
		if (fd == 0)
		begin
			$display("could not open sim/testdata_video.txt");
			$display("Errors found");
			$fatal(1, "no stimulus");
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		for (int a = 0; a < (1 << video_mem_pkg::addr_w); a++)
			write_word(a, fill_word(a)); // done long before line 80
		for (int f = 0; f < 4; f++)
		begin
			read_group(mode_next);
			@(posedge pixel_valid); // first visible line
			m0 = 4 + ($urandom % 3); // three writes land on cend 5..9, one hits vid_rd
			repeat (2 * m0 + 1) @(posedge clk);
			while (wr_addr_q.size() > 0)
				write_word(wr_addr_q.pop_front(), wr_data_q.pop_front());
			mode_atm_n_pent <= mode_next; // taken at the next frame_start
			@(posedge vblank);
		end
		repeat (2) @(negedge clk); // monitor counts the last vblank rise on the first one
		check_val("frames", frames, 5);
		$fclose(fd);
		$display("No errors");
		$finish;
	end

endmodule

/* sim/testdata_video.txt */
// kind addr data, all hex. kind 1 writes data to addr during the first visible line
// kind 0 ends the frame's records, data bit 0 is the next frame's mode (1 = atm)
1 1800 a5c3
1 2a3b 0f1e
1 3bff e4d6
0 0000 0001
0 0000 0000
1 1c47 7b29
1 2580 c3f0
1 3a9e 5186
0 0000 0001

/* tb.f */
source/video_timing_pkg.sv
source/video_mem_pkg.sv
source/video_strobe_gen.sv
source/video_sync_h.sv
source/video_sync_v.sv
source/video_fetch.sv
source/video_arbiter.sv
source/video_ram.sv
source/video_top.sv
sim/video_tb.sv
